//--- Makefile
# Verilator build and run for the x86 pre-decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_x86_predecode
FILELIST  ?= x86_predecode_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

SOURCES := $(wildcard src/*.sv) $(wildcard testbench/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
	  echo "run passed"; \
	else \
	  echo "run failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src/insn_field_merge.sv
`timescale 1ns/10ps
`default_nettype none

module insn_field_merge #(
  parameter int window_bytes = 16
) (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic [window_bytes*8-1:0]       in_bytes,
  input  wire logic                            in_valid,
  output logic                                 in_ready,
  input  wire x86_predecode_pkg::prefix_info_t info,
  output x86_predecode_pkg::table_index_t      lookup_index,
  input  wire x86_predecode_pkg::attr_t        lookup_attr,
  output logic                                 out_valid,
  input  wire logic                            out_ready,
  output x86_predecode_pkg::insn_info_t        out_insn
);
  import x86_predecode_pkg::*;

  logic [window_bytes*8-1:0] tail;  // window starting at the opcode
  logic [7:0]                opcode;
  logic [7:0]                modrm;
  logic [7:0]                sib;
  logic [1:0]                mod;
  logic [2:0]                rm;
  logic                      sib_present;
  logic [2:0]                disp_size;
  logic [2:0]                imm_size;
  logic [4:0]                length;
  logic                      started;
  insn_info_t                next_insn;

  assign tail = in_bytes >> {info.opcode_pos, 3'b000};
  assign opcode = tail[7:0];
  assign modrm = tail[15:8];
  assign sib = tail[23:16];
  assign mod = modrm[7:6];
  assign rm = modrm[2:0];

  assign lookup_index = {info.map, opcode};

  always_comb begin
    sib_present = 1'b0;
    disp_size = 3'd0;
    if (lookup_attr.has_modrm) begin
      sib_present = mod != 2'b11 && rm == 3'b100;
      case (mod)
        2'b00: begin
          if (rm == 3'b101 || (sib_present && sib[2:0] == 3'b101)) disp_size = 3'd4;
        end
        2'b01: disp_size = 3'd1;
        2'b10: disp_size = 3'd4;
        default: disp_size = 3'd0;  // register operand
      endcase
    end
  end

  always_comb begin
    imm_size = 3'd0;
    if (lookup_attr.has_imm) begin
      if (lookup_attr.imm_is_8) begin
        imm_size = 3'd1;
      end else if (info.opsize_ovr) begin
        imm_size = 3'd2;
      end else begin
        imm_size = 3'd4;
      end
    end
  end

  // worst case 26, fits in 5 bits
  assign length = 5'(info.opcode_pos) + 5'd1 + 5'(lookup_attr.has_modrm) +
                  5'(sib_present) + 5'(disp_size) + 5'(imm_size);

  always_comb begin
    next_insn.prefixes = info;
    next_insn.opcode = opcode;
    next_insn.attr = lookup_attr;
    next_insn.modrm = lookup_attr.has_modrm ? modrm : 8'h00;
    next_insn.sib = sib_present ? sib : 8'h00;
    next_insn.sib_present = sib_present;
    next_insn.disp_size = disp_size;
    next_insn.imm_size = imm_size;
    next_insn.length = length;
    next_insn.bad = info.no_opcode || length > 5'(max_insn_len);
  end

  assign in_ready = started && (!out_valid || out_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      started <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      started <= 1'b1;
      if (in_ready) out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) out_insn <= next_insn;
  end

  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_insn));

endmodule

`default_nettype wire

//--- src/opcode_attr_table.sv
`timescale 1ns/10ps
`default_nettype none

module opcode_attr_table (
  input  wire logic                                       clk,
  input  wire logic                                       rst,
  input  wire logic                                       s_axi_awvalid,
  output logic                                            s_axi_awready,
  input  wire logic [x86_predecode_pkg::axi_addr_w-1:0]   s_axi_awaddr,
  input  wire logic                                       s_axi_wvalid,
  output logic                                            s_axi_wready,
  input  wire logic [x86_predecode_pkg::axi_data_w-1:0]   s_axi_wdata,
  input  wire logic [x86_predecode_pkg::axi_strb_w-1:0]   s_axi_wstrb,
  output logic                                            s_axi_bvalid,
  input  wire logic                                       s_axi_bready,
  output logic [1:0]                                      s_axi_bresp,
  input  wire logic                                       s_axi_arvalid,
  output logic                                            s_axi_arready,
  input  wire logic [x86_predecode_pkg::axi_addr_w-1:0]   s_axi_araddr,
  output logic                                            s_axi_rvalid,
  input  wire logic                                       s_axi_rready,
  output logic [x86_predecode_pkg::axi_data_w-1:0]        s_axi_rdata,
  output logic [1:0]                                      s_axi_rresp,
  input  wire x86_predecode_pkg::table_index_t            lookup_index,
  output x86_predecode_pkg::attr_t                        lookup_attr
);
  import x86_predecode_pkg::*;

  localparam int word_bits = $clog2(table_words);

  logic [axi_data_w-1:0] mem [table_words];  // eight entries per word
  logic                  active;
  logic                  aw_full;
  logic [word_bits-1:0]  aw_word;
  logic                  w_full;
  logic [axi_data_w-1:0] w_data;
  logic [axi_strb_w-1:0] w_strb;
  logic                  aw_take;
  logic                  w_take;
  logic                  do_write;
  logic [word_bits-1:0]  wr_word;
  logic [axi_data_w-1:0] wr_data;
  logic [axi_strb_w-1:0] wr_strb;
  logic [axi_data_w-1:0] lookup_word;

  assign s_axi_awready = active && !aw_full && !s_axi_bvalid;
  assign s_axi_wready = active && !w_full && !s_axi_bvalid;
  assign s_axi_arready = active && !s_axi_rvalid;
  assign s_axi_bresp = axi_resp_okay;
  assign s_axi_rresp = axi_resp_okay;

  assign aw_take = s_axi_awvalid && s_axi_awready;
  assign w_take = s_axi_wvalid && s_axi_wready;
  assign do_write = (aw_full || aw_take) && (w_full || w_take);  // both beats in hand

  assign wr_word = aw_full ? aw_word : s_axi_awaddr[axi_addr_w-1:2];
  assign wr_data = w_full ? w_data : s_axi_wdata;
  assign wr_strb = w_full ? w_strb : s_axi_wstrb;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      aw_full <= 1'b0;
      w_full <= 1'b0;
      s_axi_bvalid <= 1'b0;
      s_axi_rvalid <= 1'b0;
    end else begin
      active <= 1'b1;
      aw_full <= (aw_full || aw_take) && !do_write;
      w_full <= (w_full || w_take) && !do_write;
      if (s_axi_bvalid && s_axi_bready) s_axi_bvalid <= 1'b0;
      if (do_write) s_axi_bvalid <= 1'b1;
      if (s_axi_arvalid && s_axi_arready) begin
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_take) aw_word <= s_axi_awaddr[axi_addr_w-1:2];
    if (w_take) begin
      w_data <= s_axi_wdata;
      w_strb <= s_axi_wstrb;
    end
    if (s_axi_arvalid && s_axi_arready) s_axi_rdata <= mem[s_axi_araddr[axi_addr_w-1:2]];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < table_words; i++) mem[i] <= '0;
    end else if (do_write) begin
      for (int b = 0; b < axi_strb_w; b++) begin
        if (wr_strb[b]) mem[wr_word][8*b +: 8] <= wr_data[8*b +: 8];
      end
    end
  end

  assign lookup_word = mem[lookup_index[9:3]];
  assign lookup_attr = attr_t'(lookup_word[{lookup_index[2:0], 2'b00} +: 4]);

  // pending write response holds and blocks the next table write
  a_no_write_in_resp: assert property (@(posedge clk) disable iff (rst)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && !do_write);

  a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

`default_nettype wire

//--- src/prefix_scanner.sv
`timescale 1ns/10ps
`default_nettype none

module prefix_scanner #(
  parameter int window_bytes = 16
) (
  input  wire logic [window_bytes*8-1:0]  in_bytes,
  output x86_predecode_pkg::prefix_info_t info
);
  import x86_predecode_pkg::*;

  logic [7:0]              lane [window_bytes];
  logic [window_bytes-1:0] is_legacy;
  logic [window_bytes-1:0] is_rex;
  logic [window_bytes-1:0] is_esc;
  logic [window_bytes-1:0] is_esc38;
  logic [window_bytes-1:0] is_esc3a;
  logic [window_bytes-1:0] esc38_next;
  logic [window_bytes-1:0] esc3a_next;

  for (genvar i = 0; i < window_bytes; i++) begin : g_lane
    assign lane[i] = in_bytes[8*i +: 8];
    assign is_legacy[i] = lane[i] inside {8'h66, 8'h67, 8'hf0, 8'hf2, 8'hf3,
                                          8'h2e, 8'h36, 8'h3e, 8'h26, 8'h64, 8'h65};
    assign is_rex[i] = lane[i][7:4] == 4'h4;
    if (i == 0) begin : g_head
      assign is_esc38[i] = 1'b0;
      assign is_esc3a[i] = 1'b0;
    end else begin : g_tail
      assign is_esc38[i] = lane[i-1] == 8'h0f && lane[i] == 8'h38;
      assign is_esc3a[i] = lane[i-1] == 8'h0f && lane[i] == 8'h3a;
    end
    assign is_esc[i] = lane[i] == 8'h0f;
  end

  // second escape byte seen from the 0f lane
  assign esc38_next = is_esc38 >> 1;
  assign esc3a_next = is_esc3a >> 1;

  always_comb begin
    int first;
    int pos;
    first = window_bytes;  // none found
    for (int i = window_bytes - 1; i >= 0; i--) begin
      if (!is_legacy[i] && !is_rex[i]) first = i;
    end
    info = '0;
    pos = first;
    for (int i = 0; i < window_bytes; i++) begin
      if (i < first) begin
        case (lane[i])
          8'h66: info.opsize_ovr = 1'b1;
          8'h67: info.addr_ovr = 1'b1;
          8'hf0: info.lock = 1'b1;
          8'hf2: info.rep = rep_repne;
          8'hf3: info.rep = rep_rep;
          8'h26: info.seg = seg_es;
          8'h2e: info.seg = seg_cs;
          8'h36: info.seg = seg_ss;
          8'h3e: info.seg = seg_ds;
          8'h64: info.seg = seg_fs;
          8'h65: info.seg = seg_gs;
          default: ;
        endcase
      end
      if (i + 1 == first && is_rex[i]) begin  // rex must touch opcode or escape
        info.rex_present = 1'b1;
        info.rex_wrxb = lane[i][3:0];
      end
      if (i == first && is_esc[i]) begin
        info.map = map_0f;
        pos = i + 1;
        if (esc38_next[i]) begin
          info.map = map_0f38;
          pos = i + 2;
        end else if (esc3a_next[i]) begin
          info.map = map_0f3a;
          pos = i + 2;
        end
      end
    end
    info.opcode_pos = 4'(pos);
    info.no_opcode = pos > window_bytes - 3;  // modrm and sib must fit
  end

endmodule

`default_nettype wire

//--- src/x86_predecode_pkg.sv
`default_nettype none

package x86_predecode_pkg;

  localparam int max_insn_len = 15;

  localparam int axi_addr_w = 9;
  localparam int axi_data_w = 32;
  localparam int axi_strb_w = axi_data_w / 8;
  localparam int table_words = 128;
  localparam logic [1:0] axi_resp_okay = 2'b00;

  // segment override codes
  localparam logic [2:0] seg_none = 3'd0;
  localparam logic [2:0] seg_es = 3'd1;
  localparam logic [2:0] seg_cs = 3'd2;
  localparam logic [2:0] seg_ss = 3'd3;
  localparam logic [2:0] seg_ds = 3'd4;
  localparam logic [2:0] seg_fs = 3'd5;
  localparam logic [2:0] seg_gs = 3'd6;

  typedef logic [9:0] table_index_t;  // {map, opcode}

  typedef enum logic [1:0] {
    one_byte,
    map_0f,
    map_0f38,
    map_0f3a
  } opmap_t;

  typedef enum logic [1:0] {
    rep_none,
    rep_repne,  // f2
    rep_rep     // f3
  } rep_t;

  typedef struct packed {
    logic has_modrm;
    logic has_imm;
    logic imm_is_8;
    logic reg_subcode;  // modrm.reg extends the opcode
  } attr_t;

  typedef struct packed {
    logic       opsize_ovr;
    logic       addr_ovr;  // reported only
    logic       lock;
    rep_t       rep;
    logic [2:0] seg;
    logic       rex_present;
    logic [3:0] rex_wrxb;
    opmap_t     map;
    logic [3:0] opcode_pos;  // byte index in window
    logic       no_opcode;
  } prefix_info_t;

  typedef struct packed {
    prefix_info_t prefixes;
    logic [7:0]   opcode;
    attr_t        attr;
    logic [7:0]   modrm;
    logic [7:0]   sib;
    logic         sib_present;
    logic [2:0]   disp_size;  // 0, 1 or 4
    logic [2:0]   imm_size;   // 0, 1, 2 or 4
    logic [4:0]   length;
    logic         bad;
  } insn_info_t;

endpackage

`default_nettype wire

//--- src/x86_predecode_top.sv
`timescale 1ns/10ps
`default_nettype none

module x86_predecode_top #(
  parameter int window_bytes = 16
) (
  input  wire logic                                     clk,
  input  wire logic                                     rst,
  input  wire logic                                     in_valid,
  output logic                                          in_ready,
  input  wire logic [window_bytes*8-1:0]                in_bytes,
  output logic                                          out_valid,
  input  wire logic                                     out_ready,
  output x86_predecode_pkg::insn_info_t                 out_insn,
  input  wire logic                                     s_axi_awvalid,
  output logic                                          s_axi_awready,
  input  wire logic [x86_predecode_pkg::axi_addr_w-1:0] s_axi_awaddr,
  input  wire logic                                     s_axi_wvalid,
  output logic                                          s_axi_wready,
  input  wire logic [x86_predecode_pkg::axi_data_w-1:0] s_axi_wdata,
  input  wire logic [x86_predecode_pkg::axi_strb_w-1:0] s_axi_wstrb,
  output logic                                          s_axi_bvalid,
  input  wire logic                                     s_axi_bready,
  output logic [1:0]                                    s_axi_bresp,
  input  wire logic                                     s_axi_arvalid,
  output logic                                          s_axi_arready,
  input  wire logic [x86_predecode_pkg::axi_addr_w-1:0] s_axi_araddr,
  output logic                                          s_axi_rvalid,
  input  wire logic                                     s_axi_rready,
  output logic [x86_predecode_pkg::axi_data_w-1:0]      s_axi_rdata,
  output logic [1:0]                                    s_axi_rresp
);
  import x86_predecode_pkg::*;

  prefix_info_t info;
  table_index_t lookup_index;
  attr_t        lookup_attr;

  prefix_scanner #(
    .window_bytes(window_bytes)
  ) u_scanner (
    .in_bytes(in_bytes),
    .info    (info)
  );

  opcode_attr_table u_table (.*);  // same port names as the top

  insn_field_merge #(
    .window_bytes(window_bytes)
  ) u_merge (
    .clk         (clk),
    .rst         (rst),
    .in_bytes    (in_bytes),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .info        (info),
    .lookup_index(lookup_index),
    .lookup_attr (lookup_attr),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_insn    (out_insn)
  );

endmodule

`default_nettype wire

//--- testbench/tb_x86_predecode.sv
`timescale 1ns/10ps
`default_nettype none

module tb_x86_predecode;
  import x86_predecode_pkg::*;

  localparam int timeout_cycles = 2000;

  typedef struct packed {
    logic [127:0] bytes;
    logic [7:0]   opcode;
    prefix_info_t pfx;
    logic [4:0]   len;
    logic [2:0]   disp;
    logic [2:0]   imm;
    logic         sib;
    logic         bad;
  } stim_t;

  logic clk, rst, in_valid, in_ready, out_valid, out_ready;
  logic [127:0] in_bytes;
  insn_info_t out_insn;
  logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready, s_axi_bvalid, s_axi_bready;
  logic s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready;
  logic [axi_addr_w-1:0] s_axi_awaddr, s_axi_araddr;
  logic [31:0] s_axi_wdata, s_axi_rdata;
  logic [3:0] s_axi_wstrb;
  logic [1:0] s_axi_bresp, s_axi_rresp;

  logic [31:0] shadow [table_words];  // expected table contents
  stim_t stims[$];
  insn_info_t expected_q[$];

  x86_predecode_top #(.window_bytes(16)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "check mismatch");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "timeout");
  endtask

  task automatic check_axi_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) report_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_attr(input attr_t got, input attr_t exp, input logic [7:0] opcode);
    if (got !== exp) report_error($sformatf("attr of %h got %b expected %b", opcode, got, exp));
  endtask

  task automatic check_insn(input insn_info_t got, input insn_info_t exp);
    if (exp.prefixes.no_opcode) begin
      if (got.bad !== 1'b1 || got.prefixes.no_opcode !== 1'b1)
        report_error("window without opcode not flagged bad");
    end else begin
      check_attr(got.attr, exp.attr, exp.opcode);
      if (got !== exp)
        report_error($sformatf("opcode %h got %h expected %h", exp.opcode, got, exp));
    end
  endtask

  // first n bytes of seq in written order, rest filled with cc
  function automatic logic [127:0] win(input logic [127:0] seq, input int n);
    logic [127:0] w;
    for (int i = 0; i < 16; i++) w[8*i +: 8] = i < n ? seq[8*(n-1-i) +: 8] : 8'hcc;
    return w;
  endfunction

  function automatic prefix_info_t pfx(input logic opsize, input logic lock, input rep_t rep,
                                       input logic [2:0] seg, input logic rex,
                                       input logic [3:0] wrxb, input opmap_t map,
                                       input logic [3:0] pos, input logic noop);
    prefix_info_t p;
    p = '0;
    p.opsize_ovr = opsize;
    p.lock = lock;
    p.rep = rep;
    p.seg = seg;
    p.rex_present = rex;
    p.rex_wrxb = wrxb;
    p.map = map;
    p.opcode_pos = pos;
    p.no_opcode = noop;
    return p;
  endfunction

  task automatic add(input logic [127:0] w, input logic [7:0] opc, input prefix_info_t p,
                     input logic [4:0] len, input logic [2:0] disp, input logic [2:0] imm,
                     input logic sib, input logic bad);
    stims.push_back('{w, opc, p, len, disp, imm, sib, bad});
  endtask

  function automatic insn_info_t expect_insn(input stim_t s);
    insn_info_t e;
    logic [9:0] idx;
    int pos;
    idx = {s.pfx.map, s.opcode};
    pos = int'(s.pfx.opcode_pos);
    e.prefixes = s.pfx;
    e.opcode = s.opcode;
    e.attr = attr_t'(shadow[idx[9:3]][{idx[2:0], 2'b00} +: 4]);
    e.modrm = e.attr.has_modrm ? s.bytes[8*(pos+1) +: 8] : 8'h00;
    e.sib = s.sib ? s.bytes[8*(pos+2) +: 8] : 8'h00;
    e.sib_present = s.sib;
    e.disp_size = s.disp;
    e.imm_size = s.imm;
    e.length = s.len;
    e.bad = s.bad;
    return e;
  endfunction

  task automatic axi_write(input logic [8:0] addr, input logic [31:0] data, input logic [3:0] strb);
    int n;
    logic aw_done, w_done;
    s_axi_awvalid <= 1'b1;
    s_axi_awaddr <= addr;
    s_axi_wvalid <= 1'b1;
    s_axi_wdata <= data;
    s_axi_wstrb <= strb;
    aw_done = 1'b0;
    w_done = 1'b0;
    n = 0;
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      n++;
      if (n > timeout_cycles) report_timeout("write address and data beats");
      if (!aw_done && s_axi_awready) begin
        aw_done = 1'b1;
        s_axi_awvalid <= 1'b0;
      end
      if (!w_done && s_axi_wready) begin
        w_done = 1'b1;
        s_axi_wvalid <= 1'b0;
      end
    end
    s_axi_bready <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > timeout_cycles) report_timeout("write response");
    end while (!s_axi_bvalid);
    s_axi_bready <= 1'b0;
    check_axi_word({30'd0, s_axi_bresp}, 32'd0, "bresp");
    for (int b = 0; b < 4; b++)
      if (strb[b]) shadow[addr[8:2]][8*b +: 8] = data[8*b +: 8];
  endtask

  task automatic axi_read(input logic [8:0] addr, output logic [31:0] data);
    int n;
    s_axi_arvalid <= 1'b1;
    s_axi_araddr <= addr;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > timeout_cycles) report_timeout("read address beat");
    end while (!s_axi_arready);
    s_axi_arvalid <= 1'b0;
    s_axi_rready <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > timeout_cycles) report_timeout("read data");
    end while (!s_axi_rvalid);
    data = s_axi_rdata;
    s_axi_rready <= 1'b0;
    check_axi_word({30'd0, s_axi_rresp}, 32'd0, "rresp");
  endtask

  task automatic run_stream(input int first, input int last);
    int n;
    for (int i = first; i < last; i++) begin
      in_valid <= 1'b1;
      in_bytes <= stims[i].bytes;
      n = 0;
      do begin
        @(posedge clk);
        n++;
        if (n > timeout_cycles) report_timeout("in_ready");
      end while (!in_ready);
      expected_q.push_back(expect_insn(stims[i]));
    end
    in_valid <= 1'b0;
    n = 0;
    while (expected_q.size() != 0) begin
      @(posedge clk);
      n++;
      if (n > timeout_cycles) report_timeout("outputs to drain");
    end
  endtask

  always @(posedge clk) begin
    insn_info_t exp;
    if (!rst) begin
      if (out_valid && out_ready) begin
        if (expected_q.size() == 0) report_error("output with no accepted window");
        exp = expected_q.pop_front();
        check_insn(out_insn, exp);
      end
      out_ready <= ($urandom % 4) != 0;  // random stalls
    end
  end

  initial begin
    logic [31:0] rd;
    void'($urandom(32'he01c_2287));
    rst = 1'b1;
    in_valid = 1'b0;
    in_bytes = '0;
    out_ready = 1'b0;
    {s_axi_awvalid, s_axi_wvalid, s_axi_bready, s_axi_arvalid, s_axi_rready} = '0;
    s_axi_awaddr = '0;
    s_axi_araddr = '0;
    s_axi_wdata = '0;
    s_axi_wstrb = '0;
    for (int i = 0; i < table_words; i++) shadow[i] = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    axi_write(9'h040, 32'hAAAA_AAAA, 4'hf);
    axi_write(9'h040, 32'h5555_F0D0, 4'h3);  // 81 and 83, upper half kept
    axi_read(9'h040, rd);
    check_axi_word(rd, 32'hAAAA_F0D0, "strobed word 16");
    axi_write(9'h044, 32'h0000_0080, 4'hf);  // 89 modrm
    axi_write(9'h05c, 32'h0000_0004, 4'hf);  // b8 imm32
    axi_write(9'h0d4, 32'h8000_0000, 4'hf);  // 0f af
    axi_write(9'h100, 32'h0000_0008, 4'hf);  // 0f 38 00
    axi_write(9'h184, 32'hE000_0000, 4'hf);  // 0f 3a 0f
    axi_read(9'h184, rd);
    check_axi_word(rd, 32'hE000_0000, "word 97");

    add(win(16'h89C0, 2), 8'h89, pfx(0, 0, rep_none, 0, 0, 0, one_byte, 0, 0), 2, 0, 0, 0, 0);
    add(win(96'h66F32EF0_48890425_78563412, 12), 8'h89,
        pfx(1, 1, rep_rep, seg_cs, 1, 4'h8, one_byte, 5, 0), 12, 4, 0, 1, 0);
    add(win(32'h486689C0, 4), 8'h89, pfx(1, 0, rep_none, 0, 0, 0, one_byte, 2, 0), 4, 0, 0, 0, 0);
    add(win(56'h0FAF0511223344, 7), 8'hAF, pfx(0, 0, rep_none, 0, 0, 0, map_0f, 1, 0),
        7, 4, 0, 0, 0);
    add(win(48'h0F38004C2408, 6), 8'h00, pfx(0, 0, rep_none, 0, 0, 0, map_0f38, 2, 0),
        6, 1, 0, 1, 0);
    add(win(40'h0F3A0FC108, 5), 8'h0F, pfx(0, 0, rep_none, 0, 0, 0, map_0f3a, 2, 0),
        5, 0, 1, 0, 0);
    add(win(80'h81804433221178563412, 10), 8'h81,
        pfx(0, 0, rep_none, 0, 0, 0, one_byte, 0, 0), 10, 4, 4, 0, 0);
    add(win(40'h6681C03412, 5), 8'h81, pfx(1, 0, rep_none, 0, 0, 0, one_byte, 1, 0),
        5, 0, 2, 0, 0);
    add(win(32'h83401005, 4), 8'h83, pfx(0, 0, rep_none, 0, 0, 0, one_byte, 0, 0), 4, 1, 1, 0, 0);
    add(win(40'hB878563412, 5), 8'hB8, pfx(0, 0, rep_none, 0, 0, 0, one_byte, 0, 0),
        5, 0, 4, 0, 0);
    add(win({16{8'h66}}, 16), 8'h00, pfx(1, 0, rep_none, 0, 0, 0, one_byte, 0, 1), 0, 0, 0, 0, 1);
    add(win(128'h2E2E2E2E2E2E2E2E2E2E_818011223344, 16), 8'h81,
        pfx(0, 0, rep_none, seg_cs, 0, 0, one_byte, 10, 0), 20, 4, 4, 0, 1);
    add(win(40'h9011223344, 5), 8'h90, pfx(0, 0, rep_none, 0, 0, 0, one_byte, 0, 0),
        1, 0, 0, 0, 0);
    add(win(40'h9011223344, 5), 8'h90, pfx(0, 0, rep_none, 0, 0, 0, one_byte, 0, 0),
        5, 0, 4, 0, 0);

    run_stream(0, stims.size() - 1);
    axi_write(9'h048, 32'h0000_0004, 4'h1);  // 90 now takes imm32
    run_stream(stims.size() - 1, stims.size());

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- x86_predecode_top.f
src/x86_predecode_pkg.sv
src/prefix_scanner.sv
src/opcode_attr_table.sv
src/insn_field_merge.sv
src/x86_predecode_top.sv
testbench/tb_x86_predecode.sv
